// File: Makefile
VERILATOR ?= verilator
TOP       ?= rv_core_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(OBJ_DIR)

// File: src/rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    typedef logic [XLEN-1:0]   word_t;
    typedef logic [REG_AW-1:0] reg_addr_t;
    typedef logic [6:0]        opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B,
        ALU_JAL,
        ALU_JALR
    } alu_op_e;

    typedef enum logic [1:0] {SRC_A_REG, SRC_A_PC, SRC_A_ZERO} alu_src_a_e;

    typedef enum logic {SRC_B_REG, SRC_B_IMM} alu_src_b_e;

    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_sel_e;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_LTU,
        BR_GEU
    } br_cond_e;

    // Major opcodes handled by the decoder
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_OP     = 7'b0110011;

    // addi x0, x0, 0
    localparam word_t NOP_INSTR  = 32'h00000013;
    // csrw 0xfff, x0 ends the run
    localparam word_t HALT_INSTR = 32'hfff01073;

endpackage

`default_nettype wire

// File: src/rv_core_top.sv
`default_nettype none

module rv_core_top
    import rv_core_pkg::*;
#(
    parameter int IMEM_DEPTH = 256
) (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      stall_i,
    input  logic      imem_we_i,
    input  word_t     imem_addr_i,
    input  word_t     imem_wdata_i,
    output logic      wb_valid_o,
    output reg_addr_t wb_rd_o,
    output word_t     wb_data_o,
    output logic      done_o
);

    word_t     if_instr;
    word_t     if_pc;
    logic      if_valid;
    reg_addr_t rf_raddr_a;
    reg_addr_t rf_raddr_b;
    word_t     rf_rdata_a;
    word_t     rf_rdata_b;
    logic      id_valid;
    word_t     id_pc;
    alu_op_e   alu_op;
    word_t     alu_src_a;
    word_t     alu_src_b;
    br_cond_e  br_cond;
    word_t     br_src_a;
    word_t     br_src_b;
    logic      rf_we;
    reg_addr_t rf_waddr;
    logic      is_jump;
    logic      id_halt;
    logic      redirect;
    word_t     redirect_pc;
    logic      wb_we;
    reg_addr_t wb_addr;
    word_t     wb_data;
    logic      halted;

    rv_fetch_stage #(
        .IMEM_DEPTH (IMEM_DEPTH)
    ) fetch_i (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .stall_i       (stall_i),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .halted_i      (halted),
        .imem_we_i     (imem_we_i),
        .imem_addr_i   (imem_addr_i),
        .imem_wdata_i  (imem_wdata_i),
        .instr_o       (if_instr),
        .pc_o          (if_pc),
        .valid_o       (if_valid)
    );

    rv_id_stage id_i (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .instr_i      (if_instr),
        .pc_i         (if_pc),
        .valid_i      (if_valid),
        .block_i      (stall_i),
        .squash_i     (redirect),
        .rf_raddr_a_o (rf_raddr_a),
        .rf_raddr_b_o (rf_raddr_b),
        .rf_rdata_a_i (rf_rdata_a),
        .rf_rdata_b_i (rf_rdata_b),
        .valid_o      (id_valid),
        .pc_o         (id_pc),
        .alu_op_o     (alu_op),
        .alu_a_o      (alu_src_a),
        .alu_b_o      (alu_src_b),
        .br_cond_o    (br_cond),
        .br_a_o       (br_src_a),
        .br_b_o       (br_src_b),
        .rf_we_o      (rf_we),
        .rf_waddr_o   (rf_waddr),
        .is_jump_o    (is_jump),
        .halt_o       (id_halt)
    );

    rv_regfile regfile_i (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .raddr_a_i (rf_raddr_a),
        .raddr_b_i (rf_raddr_b),
        .rdata_a_o (rf_rdata_a),
        .rdata_b_o (rf_rdata_b),
        .we_i      (wb_we),
        .waddr_i   (wb_addr),
        .wdata_i   (wb_data)
    );

    rv_ex_stage ex_i (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .stall_i       (stall_i),
        .valid_i       (id_valid),
        .pc_i          (id_pc),
        .alu_op_i      (alu_op),
        .alu_a_i       (alu_src_a),
        .alu_b_i       (alu_src_b),
        .br_cond_i     (br_cond),
        .br_a_i        (br_src_a),
        .br_b_i        (br_src_b),
        .rf_we_i       (rf_we),
        .rf_waddr_i    (rf_waddr),
        .is_jump_i     (is_jump),
        .halt_i        (id_halt),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc),
        .wb_we_o       (wb_we),
        .wb_addr_o     (wb_addr),
        .wb_data_o     (wb_data),
        .halted_o      (halted)
    );

    // Writes to x0 are not reported
    assign wb_valid_o = wb_we && (wb_addr != '0);
    assign wb_rd_o    = wb_addr;
    assign wb_data_o  = wb_data;
    assign done_o     = halted;

endmodule

`default_nettype wire

// File: src/rv_decoder.sv
`default_nettype none

module rv_decoder
    import rv_core_pkg::*;
(
    input  word_t      instr_i,
    output alu_op_e    alu_op_o,
    output alu_src_a_e src_a_sel_o,
    output alu_src_b_e src_b_sel_o,
    output imm_sel_e   imm_sel_o,
    output word_t      imm_o,
    output br_cond_e   br_cond_o,
    output reg_addr_t  raddr_a_o,
    output reg_addr_t  raddr_b_o,
    output reg_addr_t  waddr_o,
    output logic       rf_we_o,
    output logic       is_jump_o
);

    opcode_t    opcode;
    logic [2:0] funct3;
    logic       funct7_b5;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    alu_op_e    arith_op;

    assign opcode    = instr_i[6:0];
    assign funct3    = instr_i[14:12];
    assign funct7_b5 = instr_i[30];

    assign raddr_a_o = instr_i[19:15];
    assign raddr_b_o = instr_i[24:20];
    assign waddr_o   = instr_i[11:7];

    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
    assign imm_u = {instr_i[31:12], 12'b0};
    assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};

    // Shared funct3 map of OP and OP-IMM
    always_comb begin
        unique case (funct3)
            3'b000: arith_op = (opcode == OPC_OP && funct7_b5) ? ALU_SUB : ALU_ADD;
            3'b001: arith_op = ALU_SLL;
            3'b010: arith_op = ALU_SLT;
            3'b011: arith_op = ALU_SLTU;
            3'b100: arith_op = ALU_XOR;
            3'b101: arith_op = funct7_b5 ? ALU_SRA : ALU_SRL;
            3'b110: arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    end

    always_comb begin
        // Anything not listed behaves as a NOP
        alu_op_o    = ALU_ADD;
        src_a_sel_o = SRC_A_REG;
        src_b_sel_o = SRC_B_IMM;
        imm_sel_o   = IMM_I;
        br_cond_o   = BR_NONE;
        rf_we_o     = 1'b0;
        is_jump_o   = 1'b0;

        unique case (opcode)
            OPC_LUI: begin
                alu_op_o    = ALU_PASS_B;
                src_a_sel_o = SRC_A_ZERO;
                imm_sel_o   = IMM_U;
                rf_we_o     = 1'b1;
            end
            OPC_AUIPC: begin
                src_a_sel_o = SRC_A_PC;
                imm_sel_o   = IMM_U;
                rf_we_o     = 1'b1;
            end
            OPC_OP_IMM: begin
                alu_op_o = arith_op;
                rf_we_o  = 1'b1;
            end
            OPC_OP: begin
                alu_op_o    = arith_op;
                src_b_sel_o = SRC_B_REG;
                rf_we_o     = 1'b1;
            end
            OPC_JAL: begin
                // ALU forms the target, link value comes from execute
                alu_op_o    = ALU_JAL;
                src_a_sel_o = SRC_A_PC;
                imm_sel_o   = IMM_J;
                rf_we_o     = 1'b1;
                is_jump_o   = 1'b1;
            end
            OPC_JALR: begin
                alu_op_o  = ALU_JALR;
                rf_we_o   = 1'b1;
                is_jump_o = 1'b1;
            end
            OPC_BRANCH: begin
                src_a_sel_o = SRC_A_PC;
                imm_sel_o   = IMM_B;
                unique case (funct3)
                    3'b000:  br_cond_o = BR_EQ;
                    3'b001:  br_cond_o = BR_NE;
                    3'b100:  br_cond_o = BR_LT;
                    3'b101:  br_cond_o = BR_GE;
                    3'b110:  br_cond_o = BR_LTU;
                    3'b111:  br_cond_o = BR_GEU;
                    default: br_cond_o = BR_NONE;
                endcase
            end
            default: ;
        endcase
    end

    always_comb begin
        unique case (imm_sel_o)
            IMM_S:   imm_o = imm_s;
            IMM_B:   imm_o = imm_b;
            IMM_U:   imm_o = imm_u;
            IMM_J:   imm_o = imm_j;
            default: imm_o = imm_i;
        endcase
    end

endmodule

`default_nettype wire

// File: src/rv_ex_stage.sv
`default_nettype none

module rv_ex_stage
    import rv_core_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      stall_i,
    input  logic      valid_i,
    input  word_t     pc_i,
    input  alu_op_e   alu_op_i,
    input  word_t     alu_a_i,
    input  word_t     alu_b_i,
    input  br_cond_e  br_cond_i,
    input  word_t     br_a_i,
    input  word_t     br_b_i,
    input  logic      rf_we_i,
    input  reg_addr_t rf_waddr_i,
    input  logic      is_jump_i,
    input  logic      halt_i,
    output logic      redirect_o,
    output word_t     redirect_pc_o,
    output logic      wb_we_o,
    output reg_addr_t wb_addr_o,
    output word_t     wb_data_o,
    output logic      halted_o
);

    logic      valid_q;
    logic      halted_q;
    word_t     pc_q;
    alu_op_e   alu_op_q;
    word_t     a_q;
    word_t     b_q;
    br_cond_e  br_cond_q;
    word_t     br_a_q;
    word_t     br_b_q;
    logic      rf_we_q;
    reg_addr_t waddr_q;
    logic      is_jump_q;
    logic      halt_q;
    logic      halt_ex;
    logic      flush;
    logic      taken;
    word_t     alu_res;

    assign halt_ex = valid_q && halt_q;
    // Decode holds a wrong-path or post-halt instruction
    assign flush   = redirect_o || halt_ex || halted_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q  <= 1'b0;
            halted_q <= 1'b0;
        end else if (!stall_i) begin
            valid_q <= valid_i && !flush;
            if (halt_ex) begin
                halted_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            pc_q      <= pc_i;
            alu_op_q  <= alu_op_i;
            a_q       <= alu_a_i;
            b_q       <= alu_b_i;
            br_cond_q <= br_cond_i;
            br_a_q    <= br_a_i;
            br_b_q    <= br_b_i;
            rf_we_q   <= rf_we_i;
            waddr_q   <= rf_waddr_i;
            is_jump_q <= is_jump_i;
            halt_q    <= halt_i;
        end
    end

    always_comb begin
        unique case (alu_op_q)
            ALU_SUB:    alu_res = a_q - b_q;
            ALU_SLL:    alu_res = a_q << b_q[4:0];
            ALU_SLT:    alu_res = {31'b0, $signed(a_q) < $signed(b_q)};
            ALU_SLTU:   alu_res = {31'b0, a_q < b_q};
            ALU_XOR:    alu_res = a_q ^ b_q;
            ALU_SRL:    alu_res = a_q >> b_q[4:0];
            ALU_SRA:    alu_res = $signed(a_q) >>> b_q[4:0];
            ALU_OR:     alu_res = a_q | b_q;
            ALU_AND:    alu_res = a_q & b_q;
            ALU_PASS_B: alu_res = b_q;
            // JALR target has bit 0 cleared
            ALU_JALR:   alu_res = (a_q + b_q) & ~32'd1;
            default:    alu_res = a_q + b_q;
        endcase
    end

    always_comb begin
        unique case (br_cond_q)
            BR_EQ:   taken = (br_a_q == br_b_q);
            BR_NE:   taken = (br_a_q != br_b_q);
            BR_LT:   taken = ($signed(br_a_q) < $signed(br_b_q));
            BR_GE:   taken = ($signed(br_a_q) >= $signed(br_b_q));
            BR_LTU:  taken = (br_a_q < br_b_q);
            BR_GEU:  taken = (br_a_q >= br_b_q);
            default: taken = 1'b0;
        endcase
    end

    // Held back during a stall so the pulse lasts one active cycle
    assign redirect_o    = valid_q && !stall_i && (taken || is_jump_q);
    assign redirect_pc_o = alu_res;

    assign wb_we_o   = valid_q && rf_we_q && !stall_i;
    assign wb_addr_o = waddr_q;
    assign wb_data_o = is_jump_q ? pc_q + 32'd4 : alu_res;
    assign halted_o  = halted_q;

endmodule

`default_nettype wire

// File: src/rv_fetch_stage.sv
`default_nettype none

module rv_fetch_stage
    import rv_core_pkg::*;
#(
    parameter int IMEM_DEPTH = 256
) (
    input  logic  clk_i,
    input  logic  rst_n_i,
    input  logic  stall_i,
    input  logic  redirect_i,
    input  word_t redirect_pc_i,
    input  logic  halted_i,
    input  logic  imem_we_i,
    input  word_t imem_addr_i,
    input  word_t imem_wdata_i,
    output word_t instr_o,
    output word_t pc_o,
    output logic  valid_o
);

    localparam int ADDR_W = $clog2(IMEM_DEPTH);

    word_t imem [IMEM_DEPTH];
    word_t pc_q;
    logic  active_q;

    // Load port, word index rather than byte address
    always_ff @(posedge clk_i) begin
        if (imem_we_i) begin
            imem[imem_addr_i[ADDR_W-1:0]] <= imem_wdata_i;
        end
    end

    // Set one cycle after reset is released, so PC 0 is fetched once
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            active_q <= 1'b0;
        end else begin
            active_q <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc_q <= '0;
        end else if (redirect_i) begin
            pc_q <= redirect_pc_i;
        end else if (active_q && !stall_i && !halted_i) begin
            pc_q <= pc_q + 32'd4;
        end
    end

    assign instr_o = imem[pc_q[ADDR_W+1:2]];
    assign pc_o    = pc_q;
    // The word at PC is on the wrong path while a redirect is pending
    assign valid_o = active_q && !halted_i && !redirect_i;

endmodule

`default_nettype wire

// File: src/rv_id_stage.sv
`default_nettype none

module rv_id_stage
    import rv_core_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  word_t     instr_i,
    input  word_t     pc_i,
    input  logic      valid_i,
    input  logic      block_i,
    input  logic      squash_i,
    output reg_addr_t rf_raddr_a_o,
    output reg_addr_t rf_raddr_b_o,
    input  word_t     rf_rdata_a_i,
    input  word_t     rf_rdata_b_i,
    output logic      valid_o,
    output word_t     pc_o,
    output alu_op_e   alu_op_o,
    output word_t     alu_a_o,
    output word_t     alu_b_o,
    output br_cond_e  br_cond_o,
    output word_t     br_a_o,
    output word_t     br_b_o,
    output logic      rf_we_o,
    output reg_addr_t rf_waddr_o,
    output logic      is_jump_o,
    output logic      halt_o
);

    word_t      instr_q;
    word_t      pc_q;
    logic       valid_q;
    alu_src_a_e src_a_sel;
    alu_src_b_e src_b_sel;
    word_t      imm;

    // Fetch/decode decoupling register
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            instr_q <= NOP_INSTR;
            pc_q    <= '0;
            valid_q <= 1'b0;
        end else if (squash_i) begin
            // Wrong-path word becomes a bubble
            instr_q <= NOP_INSTR;
            valid_q <= 1'b0;
        end else if (!block_i) begin
            instr_q <= instr_i;
            pc_q    <= pc_i;
            valid_q <= valid_i;
        end
    end

    rv_decoder decoder_i (
        .instr_i     (instr_q),
        .alu_op_o    (alu_op_o),
        .src_a_sel_o (src_a_sel),
        .src_b_sel_o (src_b_sel),
        .imm_sel_o   (),
        .imm_o       (imm),
        .br_cond_o   (br_cond_o),
        .raddr_a_o   (rf_raddr_a_o),
        .raddr_b_o   (rf_raddr_b_o),
        .waddr_o     (rf_waddr_o),
        .rf_we_o     (rf_we_o),
        .is_jump_o   (is_jump_o)
    );

    always_comb begin
        unique case (src_a_sel)
            SRC_A_PC:   alu_a_o = pc_q;
            SRC_A_ZERO: alu_a_o = '0;
            default:    alu_a_o = rf_rdata_a_i;
        endcase
    end

    // Immediate or second register operand
    assign alu_b_o = (src_b_sel == SRC_B_IMM) ? imm : rf_rdata_b_i;

    // Branch comparison always works on the two source registers
    assign br_a_o = rf_rdata_a_i;
    assign br_b_o = rf_rdata_b_i;

    assign valid_o = valid_q;
    assign pc_o    = pc_q;
    assign halt_o  = valid_q && (instr_q == HALT_INSTR);

endmodule

`default_nettype wire

// File: src/rv_regfile.sv
`default_nettype none

module rv_regfile
    import rv_core_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  reg_addr_t raddr_a_i,
    input  reg_addr_t raddr_b_i,
    output word_t     rdata_a_o,
    output word_t     rdata_b_o,
    input  logic      we_i,
    input  reg_addr_t waddr_i,
    input  word_t     wdata_i
);

    // x0 has no storage
    word_t regs [1:31];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // Same-cycle write is bypassed to the readers
    assign rdata_a_o = (raddr_a_i == '0) ? '0 :
                       (we_i && waddr_i == raddr_a_i) ? wdata_i : regs[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 :
                       (we_i && waddr_i == raddr_b_i) ? wdata_i : regs[raddr_b_i];

endmodule

`default_nettype wire

// File: tb.f
src/rv_core_pkg.sv
src/rv_regfile.sv
src/rv_decoder.sv
src/rv_fetch_stage.sv
src/rv_id_stage.sv
src/rv_ex_stage.sv
src/rv_core_top.sv
verification/rv_core_chk.sv
verification/rv_core_tb.sv

// File: verification/rv_core_chk.sv
`default_nettype none

module rv_core_chk
    import rv_core_pkg::*;
(
    input logic      clk_i,
    input logic      rst_n_i,
    input logic      stall_i,
    input logic      wb_valid_o,
    input reg_addr_t wb_rd_o,
    input logic      done_o
);

    a_rd_nonzero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_valid_o |-> wb_rd_o != '0)
    else $error("wb_valid_o raised with destination x0");

    a_no_wb_in_stall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        stall_i |-> !wb_valid_o)
    else $error("wb_valid_o raised during a stall");

    // Halt is sticky until the next reset
    a_done_sticky: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        done_o |=> done_o)
    else $error("done_o dropped without reset");

    a_quiet_after_reset: assert property (@(posedge clk_i)
        $rose(rst_n_i) |-> (!wb_valid_o && !done_o))
    else $error("wb_valid_o or done_o high right after reset");

endmodule

bind rv_core_top rv_core_chk chk_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .stall_i    (stall_i),
    .wb_valid_o (wb_valid_o),
    .wb_rd_o    (wb_rd_o),
    .done_o     (done_o)
);

`default_nettype wire

// File: verification/rv_core_tb.sv
`default_nettype none

module rv_core_tb
    import rv_core_pkg::*;
;

    localparam int IMEM_DEPTH   = 256;
    localparam int PROG_LEN     = 48;
    localparam int JALR_IDX     = 28;
    localparam int NUM_PROGRAMS = 2;
    localparam int DONE_TIMEOUT = 3000;

    logic  clk_i;
    logic  rst_n_i;
    logic  stall_i;
    logic  imem_we_i;
    word_t imem_addr_i;
    word_t imem_wdata_i;
    logic  wb_valid_o;
    reg_addr_t wb_rd_o;
    word_t wb_data_o;
    logic  done_o;

    integer    seed;
    logic      running;
    int        writes_seen;
    word_t     prog_mem [IMEM_DEPTH];
    reg_addr_t exp_rd_q [$];
    word_t     exp_data_q [$];

    rv_core_top #(
        .IMEM_DEPTH (IMEM_DEPTH)
    ) dut_i (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .stall_i      (stall_i),
        .imem_we_i    (imem_we_i),
        .imem_addr_i  (imem_addr_i),
        .imem_wdata_i (imem_wdata_i),
        .wb_valid_o   (wb_valid_o),
        .wb_rd_o      (wb_rd_o),
        .wb_data_o    (wb_data_o),
        .done_o       (done_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    task automatic report_error(input string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic reg_addr_t pick_rd();
        return reg_addr_t'(1 + rand_below(7));
    endfunction

    function automatic reg_addr_t pick_rs();
        return reg_addr_t'(rand_below(8));
    endfunction

    // Instruction encoders
    function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                    input logic [2:0] f3, input reg_addr_t rd,
                                    input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3,
                                    input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t enc_b(input logic [12:0] off, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic word_t enc_j(input logic [20:0] off, input reg_addr_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    // x31 holds the JALR target and is never written by the body
    task automatic gen_program();
        int         kind;
        int         tgt;
        int         tgt_idx;
        int         br_sel;
        logic [2:0] f3;
        logic [6:0] f7;
        logic [11:0] imm;
        word_t      r;
        tgt_idx = JALR_IDX + 2 + int'(rand_below(6));
        prog_mem[0] = enc_i(12'(tgt_idx * 4), 5'd0, 3'b000, 5'd31, OPC_OP_IMM);
        prog_mem[JALR_IDX] = enc_i(12'd0, 5'd31, 3'b000, pick_rd(), OPC_JALR);
        prog_mem[PROG_LEN-1] = HALT_INSTR;
        for (int i = 1; i < PROG_LEN - 1; i++) begin
            if (i == JALR_IDX) begin
                continue;
            end
            kind = int'(rand_below(10));
            r    = $random(seed);
            f3   = 3'(rand_below(8));
            tgt  = i + 1 + int'(rand_below(6));
            if (tgt > PROG_LEN - 1) begin
                tgt = PROG_LEN - 1;
            end
            if (kind < 4) begin
                imm = r[11:0];
                if (f3 == 3'b001) begin
                    imm = {7'b0, r[4:0]};
                end else if (f3 == 3'b101) begin
                    imm = {1'b0, r[20], 5'b0, r[4:0]};
                end
                prog_mem[i] = enc_i(imm, pick_rs(), f3, pick_rd(), OPC_OP_IMM);
            end else if (kind < 6) begin
                f7 = ((f3 == 3'b000 || f3 == 3'b101) && r[31]) ? 7'b0100000 : 7'b0;
                prog_mem[i] = enc_r(f7, pick_rs(), pick_rs(), f3, pick_rd());
            end else if (kind == 6) begin
                prog_mem[i] = {r[31:12], pick_rd(), r[0] ? OPC_LUI : OPC_AUIPC};
            end else if (kind < 9) begin
                // funct3 values 0, 1, 4, 5, 6, 7
                br_sel = int'(rand_below(6));
                f3 = (br_sel < 2) ? 3'(br_sel) : 3'(br_sel + 2);
                prog_mem[i] = enc_b(13'((tgt - i) * 4), pick_rs(), pick_rs(), f3);
            end else begin
                prog_mem[i] = enc_j(21'((tgt - i) * 4), pick_rs());
            end
        end
    endtask

    function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input word_t a, input word_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // ISA-level model, fills the expected writeback list in program order
    function automatic void run_model();
        word_t      regs [32];
        word_t      pc;
        word_t      instr;
        word_t      next_pc;
        word_t      res;
        word_t      a;
        word_t      b;
        word_t      imm_i;
        reg_addr_t  rd;
        logic [2:0] f3;
        logic       wr;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        exp_rd_q.delete();
        exp_data_q.delete();
        pc = '0;
        for (int step = 0; step < 1000; step++) begin
            instr = prog_mem[pc[9:2]];
            if (instr == HALT_INSTR) begin
                break;
            end
            rd      = instr[11:7];
            f3      = instr[14:12];
            a       = regs[instr[19:15]];
            b       = regs[instr[24:20]];
            imm_i   = {{20{instr[31]}}, instr[31:20]};
            next_pc = pc + 32'd4;
            res     = '0;
            wr      = 1'b0;
            case (instr[6:0])
                OPC_LUI: begin
                    res = {instr[31:12], 12'b0};
                    wr  = 1'b1;
                end
                OPC_AUIPC: begin
                    res = pc + {instr[31:12], 12'b0};
                    wr  = 1'b1;
                end
                OPC_JAL: begin
                    res     = pc + 32'd4;
                    wr      = 1'b1;
                    next_pc = pc + {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                                    instr[30:21], 1'b0};
                end
                OPC_JALR: begin
                    res     = pc + 32'd4;
                    wr      = 1'b1;
                    next_pc = (a + imm_i) & ~32'd1;
                end
                OPC_BRANCH: begin
                    if (branch_ref(f3, a, b)) begin
                        next_pc = pc + {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                                        instr[11:8], 1'b0};
                    end
                end
                OPC_OP_IMM: begin
                    res = alu_ref(f3, f3 == 3'b101 && instr[30], a, imm_i);
                    wr  = 1'b1;
                end
                OPC_OP: begin
                    res = alu_ref(f3, instr[30], a, b);
                    wr  = 1'b1;
                end
                default: ;
            endcase
            if (wr && rd != '0) begin
                regs[rd] = res;
                exp_rd_q.push_back(rd);
                exp_data_q.push_back(res);
            end
            pc = next_pc;
        end
    endfunction

    // Program goes in while reset is held
    task automatic load_program();
        @(posedge clk_i);
        #1;
        rst_n_i = 1'b0;
        for (int i = 0; i < PROG_LEN; i++) begin
            imem_we_i    = 1'b1;
            imem_addr_i  = word_t'(i);
            imem_wdata_i = prog_mem[i];
            @(posedge clk_i);
            #1;
        end
        imem_we_i = 1'b0;
        repeat (5) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        while (done_o !== 1'b1) begin
            if (cycles >= DONE_TIMEOUT) begin
                $display("Timeout: done_o was not raised within %0d cycles", DONE_TIMEOUT);
                $display("ERRORS FOUND");
                $fatal(1, "Timeout waiting for done_o");
            end
            @(negedge clk_i);
            cycles++;
        end
    endtask

    // Random stall pulses while a program runs
    always begin
        @(posedge clk_i);
        #1;
        if (running) begin
            stall_i = (($unsigned($random(seed)) % 6) == 0);
        end else begin
            stall_i = 1'b0;
        end
    end

    // Checks every writeback against the model, mid-cycle
    always @(negedge clk_i) begin : compare_proc
        reg_addr_t exp_rd;
        word_t     exp_data;
        if (rst_n_i && wb_valid_o) begin
            assert (!done_o) else report_error("writeback after done_o was raised");
            assert (!stall_i) else report_error("writeback while stall_i is high");
            assert (wb_rd_o != '0) else report_error("writeback reported for x0");
            assert (exp_rd_q.size() > 0)
            else report_error($sformatf("unexpected write x%0d = %08h", wb_rd_o, wb_data_o));
            exp_rd   = exp_rd_q.pop_front();
            exp_data = exp_data_q.pop_front();
            assert (wb_rd_o == exp_rd && wb_data_o == exp_data)
            else report_error($sformatf("got x%0d = %08h, expected x%0d = %08h",
                                        wb_rd_o, wb_data_o, exp_rd, exp_data));
            writes_seen++;
        end
    end

    initial begin
        seed         = 32'heec7affc;
        rst_n_i      = 1'b0;
        stall_i      = 1'b0;
        imem_we_i    = 1'b0;
        imem_addr_i  = '0;
        imem_wdata_i = '0;
        running      = 1'b0;
        writes_seen  = 0;
        for (int p = 0; p < NUM_PROGRAMS; p++) begin
            gen_program();
            run_model();
            load_program();
            // Stalls start once the first cycle out of reset is under way
            @(negedge clk_i);
            running = 1'b1;
            wait_done();
            // Let anything stray after HALT show up
            repeat (8) @(negedge clk_i);
            running = 1'b0;
            assert (exp_rd_q.size() == 0)
            else report_error($sformatf("%0d expected writes never appeared", exp_rd_q.size()));
            $display("Program %0d finished, %0d writebacks checked so far", p, writes_seen);
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire
